// File: riscv_mem_subsys.f
+incdir+hw
hw/riscv_mem_pkg.sv
hw/riscv_dcache_fsm.sv
hw/riscv_dcache_array.sv
hw/riscv_dcache_align.sv
hw/riscv_timer_irq.sv
hw/riscv_mem_subsys.sv
testbench/tb_clk_gen.sv
testbench/riscv_mem_subsys_checker.sv
testbench/riscv_mem_subsys_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= riscv_mem_subsys_tb
FLIST     ?= riscv_mem_subsys.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(filter-out +incdir%,$(shell cat $(FLIST)))
HDRS := $(wildcard hw/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "No errors" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/riscv_mem_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "riscv_mem_consts.svh"

module riscv_mem_subsys_tb import riscv_mem_pkg::*; ();

  localparam int     MEM_BYTES = 2**`RISCV_ADDR;
  localparam int     N_DWORD   = 60;
  localparam int     N_SIZED   = 40;
  localparam int     N_EVICT   = 8;
  localparam int     TOTAL_OPS = N_DWORD + 2*N_SIZED + 2*N_EVICT; // cpu accesses
  localparam longint WATCH_NS  = TOTAL_OPS * 12 * 8 + 4000;

  logic                   clk;
  logic                   i_rst_n;
  cpu_req_t               i_cpu_req;
  timer_req_t             i_timer_req;
  logic                   i_mem_ready;
  blk_u                   i_mem_rdata;
  logic [`RISCV_XLEN-1:0] o_cpu_rdata;
  logic                   o_cpu_stall;
  logic [`RISCV_XLEN-1:0] o_timer_rdata;
  logic                   o_timer_irq;
  mem_req_t               o_mem_req;

  logic [7:0]  backing [MEM_BYTES];
  logic [7:0]  golden  [MEM_BYTES];
  logic [15:0] lfsr_q;
  int          errors;
  int          checks;
  int          tests;
  int          writebacks;
  int          err_mark;
  logic [`RISCV_S_ADDR-1:0] wb_addr;

  tb_clk_gen #(.PERIOD_NS(8.0)) u_clk (.o_clk(clk));

  riscv_mem_subsys u_dut (
    .i_riscv_core_clk(clk          ),
    .i_rst_n         (i_rst_n      ),
    .i_cpu_req       (i_cpu_req    ),
    .i_timer_req     (i_timer_req  ),
    .i_mem_ready     (i_mem_ready  ),
    .i_mem_rdata     (i_mem_rdata  ),
    .o_cpu_rdata     (o_cpu_rdata  ),
    .o_cpu_stall     (o_cpu_stall  ),
    .o_timer_rdata   (o_timer_rdata),
    .o_timer_irq     (o_timer_irq  ),
    .o_mem_req       (o_mem_req    )
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // stimulus source
  // ~~~~~~~~~~~~~~~~~~~~
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]; // x^16+x^14+x^13+x^11
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[62:0], lfsr_bit()};
    end
    return r;
  endfunction

  function automatic logic [7:0] fill_byte(input int a);
    return 8'((a * 7) ^ (a >> 8) ^ 8'h5a);
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~
  function automatic logic [63:0] golden_read(input logic [11:0] addr, input mem_size_e sz);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < (1 << int'(sz)); i++) begin
      r[8*i +: 8] = golden[int'(addr) + i]; // zero extended
    end
    return r;
  endfunction

  task automatic golden_write(input logic [11:0] addr, input mem_size_e sz,
                              input logic [63:0] data);
    for (int i = 0; i < (1 << int'(sz)); i++) begin
      golden[int'(addr) + i] = data[8*i +: 8];
    end
  endtask

  task automatic check_val(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("error t=%0t %s got %h exp %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // one ready pulse, write data checked against the model
  task automatic serve_mem();
    int   base;
    blk_u exp;
    base = int'({o_mem_req.addr, 4'b0000});
    if (o_mem_req.wren) begin
      for (int b = 0; b < 16; b++) begin
        exp.bytes[b] = golden[base + b];
      end
      check_val("o_mem_req.wdata", o_mem_req.wdata, exp);
      for (int b = 0; b < 16; b++) begin
        backing[base + b] = o_mem_req.wdata.bytes[b];
      end
      wb_addr = o_mem_req.addr;
      writebacks++;
    end else begin
      for (int b = 0; b < 16; b++) begin
        i_mem_rdata.bytes[b] = backing[base + b];
      end
    end
    i_mem_ready = 1'b1;
  endtask

  task automatic cpu_op(input logic wr, input mem_size_e sz, input logic [11:0] addr,
                        input logic [63:0] wdata);
    int delay;
    int cycles;
    @(negedge clk);
    i_cpu_req.wren  = wr;
    i_cpu_req.rden  = !wr;
    i_cpu_req.size  = sz;
    i_cpu_req.addr  = addr;
    i_cpu_req.wdata = wdata;
    delay  = -1;
    cycles = 0;
    forever begin
      #1;
      if (!o_cpu_stall) break;
      if (!i_mem_ready && delay < 0 && (o_mem_req.rden || o_mem_req.wren)) begin
        delay = 1 + int'(rand_bits(2)); // 1 to 4 cycles
      end
      @(negedge clk);
      i_mem_ready = 1'b0;
      cycles++;
      assert (cycles <= 64) else begin
        $display("stall never dropped for access at %h", addr);
        errors++;
      end
      if (cycles > 64) break;
      if (delay > 0) begin
        delay--;
        if (delay == 0) begin
          serve_mem();
          delay = -1;
        end
      end
    end
    if (wr) begin
      golden_write(addr, sz, wdata);
    end else begin
      check_val("o_cpu_rdata", o_cpu_rdata, golden_read(addr, sz));
    end
  endtask

  task automatic timer_write(input logic [1:0] sel, input logic [63:0] data);
    @(negedge clk);
    i_timer_req.wren   = 1'b1;
    i_timer_req.regsel = sel;
    i_timer_req.wdata  = data;
    @(negedge clk);
    i_timer_req.wren   = 1'b0;
  endtask

  task automatic timer_read(input logic [1:0] sel, output logic [63:0] data);
    i_timer_req.rden   = 1'b1;
    i_timer_req.regsel = sel;
    #1;
    data               = o_timer_rdata;
    i_timer_req.rden   = 1'b0;
  endtask

  task automatic report_test(input string name);
    tests++;
    $display("test %s: %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  initial begin
    #(WATCH_NS);
    $display("watchdog expired, the run hung");
    $display("Errors found");
    $finish;
  end

  initial begin
    logic [11:0] addr;
    logic [63:0] r;
    logic [63:0] m0;
    logic [63:0] cmp;
    mem_size_e   sz;
    int          wb_mark;
    int          k;
    i_rst_n     = 1'b0;
    i_cpu_req   = '0;
    i_timer_req = '0;
    i_mem_ready = 1'b0;
    i_mem_rdata = '0;
    lfsr_q      = 16'd62;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    writebacks  = 0;
    err_mark    = 0;
    wb_addr     = '0;
    for (int a = 0; a < MEM_BYTES; a++) begin
      backing[a] = fill_byte(a);
      golden[a]  = fill_byte(a);
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    i_rst_n = 1'b1;

    // reset state
    @(negedge clk);
    check_val("o_cpu_stall", o_cpu_stall, 0);
    check_val("o_mem_req.rden", o_mem_req.rden, 0);
    check_val("o_mem_req.wren", o_mem_req.wren, 0);
    check_val("o_timer_irq", o_timer_irq, 0);
    timer_read(2'(`RISCV_TMR_MTIME), r);
    assert (r < 16) else begin
      $display("mtime after reset is not a small count: %0d", r);
      errors++;
    end
    report_test("reset");

    // doublewords over two conflicting indices
    for (int n = 0; n < N_DWORD; n++) begin
      addr = {4'(rand_bits(4)), 3'b000, 1'(rand_bits(1)), 1'(rand_bits(1)), 3'b000};
      cpu_op(1'(rand_bits(1)), SZ_DOUBLE, addr, rand_bits(64));
    end
    report_test("dword");

    // sized stores, each followed by a dword load
    for (int n = 0; n < N_SIZED; n++) begin
      sz   = mem_size_e'(2'(rand_bits(2)));
      addr = {4'(rand_bits(4)), 3'b000, 1'(rand_bits(1)), 4'(rand_bits(4))};
      addr = addr & ~12'((1 << int'(sz)) - 1); // natural alignment
      cpu_op(1'b1, sz, addr, rand_bits(64));
      cpu_op(1'b0, SZ_DOUBLE, {addr[11:3], 3'b000}, '0);
    end
    report_test("sized");

    // evictions on line 2
    wb_mark = writebacks;
    for (int t = 0; t < N_EVICT; t++) begin
      cpu_op(1'b1, SZ_DOUBLE, {4'(t), 4'd2, 4'b1000}, rand_bits(64));
      if (t > 0) begin
        check_val("o_mem_req.addr", 128'(wb_addr), 128'({4'(t - 1), 4'd2})); // previous tag
      end
    end
    check_val("writebacks", 128'(writebacks - wb_mark), 128'(N_EVICT - 1));
    for (int t = 0; t < N_EVICT; t++) begin
      cpu_op(1'b0, SZ_DOUBLE, {4'(t), 4'd2, 4'b1000}, '0);
    end
    @(negedge clk);
    i_cpu_req = '0;
    report_test("evict");

    // timer registers
    r = rand_bits(40);
    timer_write(2'(`RISCV_TMR_MTIME), r);
    k = 3 + int'(rand_bits(3));
    repeat (k) @(negedge clk);
    timer_read(2'(`RISCV_TMR_MTIME), m0);
    check_val("o_timer_rdata", m0, r + 64'(k));
    cmp = 64'hffff_0000_0000_0000 | rand_bits(32);
    timer_write(2'(`RISCV_TMR_MTIMECMP), cmp);
    timer_read(2'(`RISCV_TMR_MTIMECMP), r);
    check_val("o_timer_rdata", r, cmp);
    report_test("timer_regs");

    // interrupt at mtime + 8
    @(negedge clk);
    timer_read(2'(`RISCV_TMR_MTIME), m0);
    cmp = m0 + 64'd8;
    timer_write(2'(`RISCV_TMR_MTIMECMP), cmp);
    check_val("o_timer_irq", o_timer_irq, 0);
    for (int j = 1; j <= 12; j++) begin
      @(negedge clk);
      check_val("o_timer_irq", o_timer_irq, 128'(m0 + 64'(1 + j) >= cmp));
    end
    timer_write(2'(`RISCV_TMR_MTIMECMP), cmp + 64'd1000);
    @(negedge clk);
    check_val("o_timer_irq", o_timer_irq, 0);
    report_test("timer_irq");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/riscv_mem_subsys_checker.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_mem_subsys_checker import riscv_mem_pkg::*; (
  input logic     i_clk      ,
  input logic     i_rst_n    ,
  input cpu_req_t i_cpu_req  ,
  input logic     i_hit      ,
  input logic     i_cpu_stall,
  input mem_req_t i_mem_req  ,
  input logic     i_mem_ready
);

  logic idle;
  logic miss;

  // no strobe means the controller sits in IDLE
  assign idle = !i_mem_req.rden && !i_mem_req.wren;
  assign miss = (i_cpu_req.rden || i_cpu_req.wren) && !i_hit;

  a_one_strobe: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_mem_req.rden && i_mem_req.wren))
    else $error("memory read and write strobes high together");

  a_rden_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_mem_req.rden && !i_mem_ready) |=> i_mem_req.rden)
    else $error("memory read strobe dropped before ready");

  a_wren_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_mem_req.wren && !i_mem_ready) |=> i_mem_req.wren)
    else $error("memory write strobe dropped before ready");

  a_no_stall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (idle && !miss) |-> !i_cpu_stall)
    else $error("stall high in IDLE without a miss");

endmodule

bind riscv_mem_subsys riscv_mem_subsys_checker u_checker (
  .i_clk      (i_riscv_core_clk),
  .i_rst_n    (i_rst_n         ),
  .i_cpu_req  (i_cpu_req       ),
  .i_hit      (dcache_hit      ),
  .i_cpu_stall(o_cpu_stall     ),
  .i_mem_req  (o_mem_req       ),
  .i_mem_ready(i_mem_ready     )
);

`default_nettype wire

// File: testbench/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter real PERIOD_NS = 8.0
) (
  output logic o_clk
);

  initial o_clk = 1'b0;

  always #(PERIOD_NS/2.0) o_clk = ~o_clk; // free running

endmodule

`default_nettype wire

// File: hw/riscv_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none
`include "riscv_mem_consts.svh"

module riscv_mem_subsys import riscv_mem_pkg::*; (
  input  logic                   i_riscv_core_clk,
  input  logic                   i_rst_n         ,
  input  cpu_req_t               i_cpu_req       ,
  input  timer_req_t             i_timer_req     ,
  input  logic                   i_mem_ready     ,
  input  blk_u                   i_mem_rdata     ,
  output logic [`RISCV_XLEN-1:0] o_cpu_rdata     ,
  output logic                   o_cpu_stall     ,
  output logic [`RISCV_XLEN-1:0] o_timer_rdata   ,
  output logic                   o_timer_irq     ,
  output mem_req_t               o_mem_req
);

  // ~~~~~~~~~~~~~~~~~~~~
  // data cache wires
  // ~~~~~~~~~~~~~~~~~~~~
  logic       dcache_hit;
  line_meta_t dcache_meta; // resident line, also the victim on a miss
  blk_u       dcache_blk;
  blk_u       align_store_blk;
  logic       fsm_fill;
  logic       fsm_store_en;

  riscv_dcache_fsm u_dcache_fsm (
    .i_riscv_dcache_clk(i_riscv_core_clk),
    .i_rst_n           (i_rst_n         ),
    .i_cpu_req         (i_cpu_req       ),
    .i_hit             (dcache_hit      ),
    .i_victim_meta     (dcache_meta     ),
    .i_victim_blk      (dcache_blk      ),
    .i_mem_ready       (i_mem_ready     ),
    .o_cpu_stall       (o_cpu_stall     ),
    .o_fill            (fsm_fill        ),
    .o_store_en        (fsm_store_en    ),
    .o_mem_req         (o_mem_req       )
  );

  riscv_dcache_array u_dcache_array (
    .i_riscv_dcache_clk(i_riscv_core_clk),
    .i_rst_n           (i_rst_n         ),
    .i_addr            (i_cpu_req.addr  ),
    .i_fill            (fsm_fill        ),
    .i_fill_blk        (i_mem_rdata     ), // fill straight from memory
    .i_store_en        (fsm_store_en    ),
    .i_store_blk       (align_store_blk ),
    .o_hit             (dcache_hit      ),
    .o_meta            (dcache_meta     ),
    .o_blk             (dcache_blk      )
  );

  riscv_dcache_align u_dcache_align (
    .i_blk      (dcache_blk                                ),
    .i_offset   (i_cpu_req.addr[`RISCV_BYTE_OFF-1:0]       ),
    .i_size     (i_cpu_req.size                            ),
    .i_wdata    (i_cpu_req.wdata                           ),
    .o_store_blk(align_store_blk                           ),
    .o_load_data(o_cpu_rdata                               )
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // machine timer
  // ~~~~~~~~~~~~~~~~~~~~
  riscv_timer_irq u_riscv_timer_irq (
    .i_riscv_timer_clk(i_riscv_core_clk),
    .i_rst_n          (i_rst_n         ),
    .i_timer_req      (i_timer_req     ),
    .o_timer_rdata    (o_timer_rdata   ),
    .o_timer_irq      (o_timer_irq     )
  );

endmodule

`default_nettype wire

// File: hw/riscv_timer_irq.sv
`timescale 1ns/1ps
`default_nettype none
`include "riscv_mem_consts.svh"

module riscv_timer_irq import riscv_mem_pkg::*; (
  input  logic                   i_riscv_timer_clk,
  input  logic                   i_rst_n          ,
  input  timer_req_t             i_timer_req      ,
  output logic [`RISCV_XLEN-1:0] o_timer_rdata    ,
  output logic                   o_timer_irq
);

  logic [`RISCV_XLEN-1:0] mtime_q;
  logic [`RISCV_XLEN-1:0] mtimecmp_q;
  logic                   sel_mtime;
  logic                   sel_mtimecmp;

  assign sel_mtime    = (i_timer_req.regsel == 2'(`RISCV_TMR_MTIME));
  assign sel_mtimecmp = (i_timer_req.regsel == 2'(`RISCV_TMR_MTIMECMP));

  always_ff @(posedge i_riscv_timer_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1; // no interrupt until programmed
      o_timer_irq <= 1'b0;
    end else begin
      if (i_timer_req.wren && sel_mtime) begin
        mtime_q <= i_timer_req.wdata;
      end else begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (i_timer_req.wren && sel_mtimecmp) begin
        mtimecmp_q <= i_timer_req.wdata;
      end
      o_timer_irq <= (mtime_q >= mtimecmp_q);
    end
  end

  // register read, unused selects give zero
  always_comb begin
    o_timer_rdata = '0;
    if (i_timer_req.rden) begin
      if (sel_mtime) begin
        o_timer_rdata = mtime_q;
      end else if (sel_mtimecmp) begin
        o_timer_rdata = mtimecmp_q;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/riscv_dcache_align.sv
`timescale 1ns/1ps
`default_nettype none
`include "riscv_mem_consts.svh"

module riscv_dcache_align import riscv_mem_pkg::*; (
  input  blk_u                       i_blk      ,
  input  logic [`RISCV_BYTE_OFF-1:0] i_offset   ,
  input  mem_size_e                  i_size     ,
  input  logic [`RISCV_XLEN-1:0]     i_wdata    ,
  output blk_u                       o_store_blk,
  output logic [`RISCV_XLEN-1:0]     o_load_data
);

  localparam int DW_BYTES = `RISCV_XLEN/8;

  logic [`RISCV_XLEN-1:0] dword;
  logic [`RISCV_XLEN-1:0] dword_sh;
  logic [`RISCV_XLEN-1:0] load_mask;
  logic [`RISCV_XLEN-1:0] wdata_sh;
  logic [DW_BYTES-1:0]    size_be;
  logic [DW_BYTES-1:0]    byte_en;

  always_comb begin
    case (i_size)
      SZ_BYTE: begin
        load_mask = 64'h0000_0000_0000_00ff;
        size_be   = 8'h01;
      end
      SZ_HALF: begin
        load_mask = 64'h0000_0000_0000_ffff;
        size_be   = 8'h03;
      end
      SZ_WORD: begin
        load_mask = 64'h0000_0000_ffff_ffff;
        size_be   = 8'h0f;
      end
      default: begin
        load_mask = '1;
        size_be   = '1;
      end
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // load path
  // ~~~~~~~~~~~~~~~~~~~~
  assign dword       = i_blk.dwords[i_offset[3]];
  assign dword_sh    = dword >> {i_offset[2:0], 3'b000};
  assign o_load_data = dword_sh & load_mask; // zero extended

  // ~~~~~~~~~~~~~~~~~~~~
  // store merge
  // ~~~~~~~~~~~~~~~~~~~~
  assign wdata_sh = i_wdata << {i_offset[2:0], 3'b000};
  assign byte_en  = size_be << i_offset[2:0];

  always_comb begin
    o_store_blk = i_blk;
    for (int b = 0; b < `RISCV_BLK_W/8; b++) begin
      if ((b / DW_BYTES) == int'(i_offset[3]) && byte_en[b % DW_BYTES]) begin
        o_store_blk.bytes[b] = wdata_sh[8*(b % DW_BYTES) +: 8];
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/riscv_dcache_array.sv
`timescale 1ns/1ps
`default_nettype none
`include "riscv_mem_consts.svh"

module riscv_dcache_array import riscv_mem_pkg::*; (
  input  logic                   i_riscv_dcache_clk,
  input  logic                   i_rst_n           ,
  input  logic [`RISCV_ADDR-1:0] i_addr            ,
  input  logic                   i_fill            ,
  input  blk_u                   i_fill_blk        ,
  input  logic                   i_store_en        ,
  input  blk_u                   i_store_blk       ,
  output logic                   o_hit             ,
  output line_meta_t             o_meta            ,
  output blk_u                   o_blk
);

  localparam int LINES = 2**`RISCV_INDEX;

  line_meta_t              meta_q [LINES];
  blk_u                    blk_q  [LINES];
  logic [`RISCV_INDEX-1:0] index;
  logic [`RISCV_TAG-1:0]   tag;

  assign index = i_addr[`RISCV_BYTE_OFF +: `RISCV_INDEX];
  assign tag   = i_addr[`RISCV_ADDR-1 -: `RISCV_TAG];

  // ~~~~~~~~~~~~~~~~~~~~
  // line metadata
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge i_riscv_dcache_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < LINES; i++) begin
        meta_q[i] <= '0;
      end
    end else if (i_fill) begin
      meta_q[index].valid <= 1'b1;
      meta_q[index].dirty <= 1'b0; // clean copy of memory
      meta_q[index].tag   <= tag;
    end else if (i_store_en) begin
      meta_q[index].dirty <= 1'b1;
    end
  end

  // block storage
  always_ff @(posedge i_riscv_dcache_clk) begin
    if (i_fill) begin
      blk_q[index] <= i_fill_blk;
    end else if (i_store_en) begin
      blk_q[index] <= i_store_blk;
    end
  end

  // resident line, read by index
  assign o_meta = meta_q[index];
  assign o_blk  = blk_q[index];
  assign o_hit  = o_meta.valid && (o_meta.tag == tag);

endmodule

`default_nettype wire

// File: hw/riscv_dcache_fsm.sv
`timescale 1ns/1ps
`default_nettype none
`include "riscv_mem_consts.svh"

module riscv_dcache_fsm import riscv_mem_pkg::*; (
  input  logic       i_riscv_dcache_clk,
  input  logic       i_rst_n           ,
  input  cpu_req_t   i_cpu_req         ,
  input  logic       i_hit             ,
  input  line_meta_t i_victim_meta     ,
  input  blk_u       i_victim_blk      ,
  input  logic       i_mem_ready       ,
  output logic       o_cpu_stall       ,
  output logic       o_fill            ,
  output logic       o_store_en        ,
  output mem_req_t   o_mem_req
);

  dcache_state_e           state_q;
  dcache_state_e           state_d;
  logic                    cpu_access;
  logic                    miss;
  logic [`RISCV_INDEX-1:0] req_index;
  logic [`RISCV_TAG-1:0]   req_tag;

  assign cpu_access = i_cpu_req.wren | i_cpu_req.rden;
  assign miss       = cpu_access & ~i_hit;
  assign req_index  = i_cpu_req.addr[`RISCV_BYTE_OFF +: `RISCV_INDEX];
  assign req_tag    = i_cpu_req.addr[`RISCV_ADDR-1 -: `RISCV_TAG];

  always_ff @(posedge i_riscv_dcache_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (miss) begin
          // dirty victim goes out first
          state_d = (i_victim_meta.valid && i_victim_meta.dirty) ? WRITEBACK : ALLOCATE;
        end
      end
      WRITEBACK: if (i_mem_ready) state_d = ALLOCATE;
      ALLOCATE:  if (i_mem_ready) state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // outputs
  // ~~~~~~~~~~~~~~~~~~~~
  assign o_cpu_stall = (state_q != IDLE) | miss;
  assign o_fill      = (state_q == ALLOCATE) & i_mem_ready;
  assign o_store_en  = (state_q == IDLE) & i_cpu_req.wren & i_hit;

  always_comb begin
    o_mem_req = '0;
    case (state_q)
      WRITEBACK: begin
        o_mem_req.wren  = 1'b1;
        o_mem_req.addr  = {i_victim_meta.tag, req_index}; // victim block address
        o_mem_req.wdata = i_victim_blk;
      end
      ALLOCATE: begin
        o_mem_req.rden = 1'b1;
        o_mem_req.addr = {req_tag, req_index};
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/riscv_mem_pkg.sv
`default_nettype none
`include "riscv_mem_consts.svh"

package riscv_mem_pkg;

  // same encoding as the core's store source
  typedef enum logic [1:0] {
    SZ_BYTE   = 2'b00,
    SZ_HALF   = 2'b01,
    SZ_WORD   = 2'b10,
    SZ_DOUBLE = 2'b11
  } mem_size_e;

  typedef struct packed {
    logic                    wren;
    logic                    rden;
    mem_size_e               size;
    logic [`RISCV_ADDR-1:0]  addr;
    logic [`RISCV_XLEN-1:0]  wdata;
  } cpu_req_t;

  typedef struct packed {
    logic                    wren;
    logic                    rden;
    logic [1:0]              regsel;
    logic [`RISCV_XLEN-1:0]  wdata;
  } timer_req_t;

  // one block, seen as doublewords or as bytes
  typedef union packed {
    logic [`RISCV_BLK_W/`RISCV_XLEN-1:0][`RISCV_XLEN-1:0] dwords;
    logic [`RISCV_BLK_W/8-1:0][7:0]                        bytes;
  } blk_u;

  typedef struct packed {
    logic                     rden;
    logic                     wren;
    logic [`RISCV_S_ADDR-1:0] addr;
    blk_u                     wdata;
  } mem_req_t;

  typedef struct packed {
    logic                  valid;
    logic                  dirty;
    logic [`RISCV_TAG-1:0] tag;
  } line_meta_t;

  typedef enum logic [1:0] {
    IDLE,
    WRITEBACK,
    ALLOCATE
  } dcache_state_e;

endpackage

`default_nettype wire

// File: hw/riscv_mem_consts.svh
`ifndef RISCV_MEM_CONSTS_SVH
`define RISCV_MEM_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// data widths
// ~~~~~~~~~~~~~~~~~~~~
`define RISCV_XLEN         64
`define RISCV_BLK_W        128

// ~~~~~~~~~~~~~~~~~~~~
// address split: tag | index | byte offset
// ~~~~~~~~~~~~~~~~~~~~
`define RISCV_ADDR         12   // 4 KiB backing memory
`define RISCV_BYTE_OFF     4    // 16 bytes per block
`define RISCV_INDEX        4    // 16 lines
`define RISCV_TAG          4
`define RISCV_S_ADDR       8    // block address toward memory

// ~~~~~~~~~~~~~~~~~~~~
// timer register selects
// ~~~~~~~~~~~~~~~~~~~~
`define RISCV_TMR_MTIME    0
`define RISCV_TMR_MTIMECMP 1

`endif
